// ==== hdl/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OP_W       = 6;

    // operand source select; the code is the mux input index
    typedef enum logic [1:0] {
        FWD_REG    = 2'd0,
        FWD_EX_MEM = 2'd1,
        FWD_MEM_WB = 2'd2,
        FWD_ID_EX  = 2'd3
    } fwd_sel_t;

    typedef struct packed {
        logic [OP_W-1:0]       op;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
        logic [4:0]            shamt;
        logic [5:0]            funct;
    } r_type_t;

    typedef struct packed {
        logic [OP_W-1:0]       op;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [15:0]           imm16;
    } i_type_t;

    // same 32-bit word, R-type or I-type view
    typedef union packed {
        r_type_t rtype;
        i_type_t itype;
    } instr_u;

endpackage

`default_nettype wire

// ==== hdl/fwd_bus_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface fwd_bus_if;
    import mips_pkg::*;

    logic [REG_ADDR_W-1:0] rd_id_ex;
    logic                  wr_id_ex;
    logic [XLEN-1:0]       data_id_ex;

    logic [REG_ADDR_W-1:0] rd_ex_mem;
    logic                  wr_ex_mem;
    logic [XLEN-1:0]       data_ex_mem;

    logic [REG_ADDR_W-1:0] rd_mem_wb;
    logic                  wr_mem_wb;
    logic [XLEN-1:0]       data_mem_wb;

    modport src (
        output rd_id_ex, wr_id_ex, data_id_ex,
        output rd_ex_mem, wr_ex_mem, data_ex_mem,
        output rd_mem_wb, wr_mem_wb, data_mem_wb
    );

    modport dst (
        input rd_id_ex, wr_id_ex, data_id_ex,
        input rd_ex_mem, wr_ex_mem, data_ex_mem,
        input rd_mem_wb, wr_mem_wb, data_mem_wb
    );

endinterface

`default_nettype wire

// ==== hdl/register_bank.sv ====
`timescale 1ns/1ns
`default_nettype none

module register_bank #(
    parameter int NUM_REGISTERS = 32
) (
    input  wire logic                            clk,
    input  wire logic                            i_rst,
    input  wire logic                            i_w_en,
    input  wire logic [mips_pkg::REG_ADDR_W-1:0] i_w_addr,
    input  wire logic [mips_pkg::XLEN-1:0]       i_w_data,
    input  wire logic [mips_pkg::REG_ADDR_W-1:0] i_addr_a,
    input  wire logic [mips_pkg::REG_ADDR_W-1:0] i_addr_b,
    output logic [mips_pkg::XLEN-1:0]            o_data_a,
    output logic [mips_pkg::XLEN-1:0]            o_data_b
);
    import mips_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGISTERS];

    if (NUM_REGISTERS > 2**REG_ADDR_W) begin : g_size_check
        $error("NUM_REGISTERS does not fit in REG_ADDR_W address bits");
    end

    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
        logic [XLEN-1:0] value;
        value = '0;
        if (addr == '0) begin
            value = '0; // r0 is hardwired
        end else if (i_w_en && i_w_addr == addr) begin
            value = i_w_data; // write-through
        end else if (int'(addr) < NUM_REGISTERS) begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int k = 0; k < NUM_REGISTERS; k++) begin
                regs[k] <= '0;
            end
        end else if (i_w_en && i_w_addr != '0 && int'(i_w_addr) < NUM_REGISTERS) begin
            regs[i_w_addr] <= i_w_data;
        end
    end

    always_comb begin
        o_data_a = read_port(i_addr_a);
        o_data_b = read_port(i_addr_b);
    end

    a_r0_zero: assert property (@(posedge clk) disable iff (i_rst)
        ((i_addr_a == '0) |-> (o_data_a == '0)) and
        ((i_addr_b == '0) |-> (o_data_b == '0)))
        else $error("register 0 read returned a nonzero value");

endmodule

`default_nettype wire

// ==== hdl/forwarding_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module forwarding_unit (
    input  wire logic [mips_pkg::REG_ADDR_W-1:0] i_rs,
    input  wire logic [mips_pkg::REG_ADDR_W-1:0] i_rt,
    input  wire logic [mips_pkg::REG_ADDR_W-1:0] i_rd_id_ex,
    input  wire logic                            i_wr_id_ex,
    input  wire logic [mips_pkg::REG_ADDR_W-1:0] i_rd_ex_mem,
    input  wire logic                            i_wr_ex_mem,
    input  wire logic [mips_pkg::REG_ADDR_W-1:0] i_rd_mem_wb,
    input  wire logic                            i_wr_mem_wb,
    output mips_pkg::fwd_sel_t                   o_fwd_a,
    output mips_pkg::fwd_sel_t                   o_fwd_b
);
    import mips_pkg::*;

    // youngest matching stage wins
    function automatic fwd_sel_t pick_source(input logic [REG_ADDR_W-1:0] src);
        fwd_sel_t sel;
        sel = FWD_REG;
        if (src != '0) begin
            if (i_wr_id_ex && i_rd_id_ex == src) begin
                sel = FWD_ID_EX;
            end else if (i_wr_ex_mem && i_rd_ex_mem == src) begin
                sel = FWD_EX_MEM;
            end else if (i_wr_mem_wb && i_rd_mem_wb == src) begin
                sel = FWD_MEM_WB;
            end
        end
        return sel;
    endfunction

    always_comb begin
        o_fwd_a = pick_source(i_rs);
        o_fwd_b = pick_source(i_rt);
    end

endmodule

`default_nettype wire

// ==== hdl/instruction_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module instruction_decode #(
    parameter int NUM_REGISTERS = 32
) (
    input  wire logic                            clk,
    input  wire logic                            i_rst,
    input  wire mips_pkg::instr_u                i_instruction,
    input  wire logic                            i_w_en,
    input  wire logic [mips_pkg::REG_ADDR_W-1:0] i_w_addr,
    input  wire logic [mips_pkg::XLEN-1:0]       i_w_data,
    fwd_bus_if.dst                               fwd,
    output logic [mips_pkg::OP_W-1:0]            o_op,
    output logic [mips_pkg::REG_ADDR_W-1:0]      o_rs,
    output logic [mips_pkg::REG_ADDR_W-1:0]      o_rt,
    output logic [mips_pkg::REG_ADDR_W-1:0]      o_rd,
    output logic [mips_pkg::XLEN-1:0]            o_imm,
    output logic [mips_pkg::XLEN-1:0]            o_reg_a,
    output logic [mips_pkg::XLEN-1:0]            o_reg_b
);
    import mips_pkg::*;

    logic [XLEN-1:0] bank_a;
    logic [XLEN-1:0] bank_b;
    fwd_sel_t        fwd_a;
    fwd_sel_t        fwd_b;

    function automatic logic [XLEN-1:0] operand_mux(
        input fwd_sel_t        sel,
        input logic [XLEN-1:0] bank,
        input logic [XLEN-1:0] id_ex,
        input logic [XLEN-1:0] ex_mem,
        input logic [XLEN-1:0] mem_wb
    );
        logic [XLEN-1:0] value;
        case (sel)
            FWD_EX_MEM: value = ex_mem;
            FWD_MEM_WB: value = mem_wb;
            FWD_ID_EX:  value = id_ex;
            default:    value = bank;
        endcase
        return value;
    endfunction

    register_bank #(
        .NUM_REGISTERS(NUM_REGISTERS)
    ) register_bank_i (
        .clk      (clk),
        .i_rst    (i_rst),
        .i_w_en   (i_w_en),
        .i_w_addr (i_w_addr),
        .i_w_data (i_w_data),
        .i_addr_a (i_instruction.rtype.rs),
        .i_addr_b (i_instruction.rtype.rt),
        .o_data_a (bank_a),
        .o_data_b (bank_b)
    );

    forwarding_unit forwarding_unit_i (
        .i_rs        (i_instruction.rtype.rs),
        .i_rt        (i_instruction.rtype.rt),
        .i_rd_id_ex  (fwd.rd_id_ex),
        .i_wr_id_ex  (fwd.wr_id_ex),
        .i_rd_ex_mem (fwd.rd_ex_mem),
        .i_wr_ex_mem (fwd.wr_ex_mem),
        .i_rd_mem_wb (fwd.rd_mem_wb),
        .i_wr_mem_wb (fwd.wr_mem_wb),
        .o_fwd_a     (fwd_a),
        .o_fwd_b     (fwd_b)
    );

    always_comb begin
        o_op    = i_instruction.rtype.op;
        o_rs    = i_instruction.rtype.rs;
        o_rt    = i_instruction.rtype.rt;
        o_rd    = i_instruction.rtype.rd;
        o_imm   = {{(XLEN-16){i_instruction.itype.imm16[15]}}, i_instruction.itype.imm16};
        o_reg_a = operand_mux(fwd_a, bank_a, fwd.data_id_ex, fwd.data_ex_mem, fwd.data_mem_wb);
        o_reg_b = operand_mux(fwd_b, bank_b, fwd.data_id_ex, fwd.data_ex_mem, fwd.data_mem_wb);
    end

    // r0 must never pick up forwarded data
    a_no_fwd_r0: assert property (@(posedge clk) disable iff (i_rst)
        ((o_rs == '0) |-> (fwd_a == FWD_REG)) and ((o_rt == '0) |-> (fwd_b == FWD_REG)))
        else $error("forwarding selected for register 0");

endmodule

`default_nettype wire

// ==== hdl/id_ex_register.sv ====
`timescale 1ns/1ns
`default_nettype none

module id_ex_register (
    input  wire logic                            clk,
    input  wire logic                            i_rst,
    input  wire logic                            i_stall,
    input  wire logic [mips_pkg::OP_W-1:0]       i_op,
    input  wire logic [mips_pkg::REG_ADDR_W-1:0] i_rs,
    input  wire logic [mips_pkg::REG_ADDR_W-1:0] i_rt,
    input  wire logic [mips_pkg::REG_ADDR_W-1:0] i_rd,
    input  wire logic [mips_pkg::XLEN-1:0]       i_imm,
    input  wire logic [mips_pkg::XLEN-1:0]       i_reg_a,
    input  wire logic [mips_pkg::XLEN-1:0]       i_reg_b,
    output logic                                 o_valid,
    output logic [mips_pkg::OP_W-1:0]            o_op,
    output logic [mips_pkg::REG_ADDR_W-1:0]      o_rs,
    output logic [mips_pkg::REG_ADDR_W-1:0]      o_rt,
    output logic [mips_pkg::REG_ADDR_W-1:0]      o_rd,
    output logic [mips_pkg::XLEN-1:0]            o_imm,
    output logic [mips_pkg::XLEN-1:0]            o_reg_a,
    output logic [mips_pkg::XLEN-1:0]            o_reg_b
);
    import mips_pkg::*;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_valid <= 1'b0;
            o_op    <= '0;
            o_rs    <= '0;
            o_rt    <= '0;
            o_rd    <= '0;
            o_imm   <= '0;
            o_reg_a <= '0;
            o_reg_b <= '0;
        end else if (!i_stall) begin
            o_valid <= 1'b1; // first unstalled edge after reset
            o_op    <= i_op;
            o_rs    <= i_rs;
            o_rt    <= i_rt;
            o_rd    <= i_rd;
            o_imm   <= i_imm;
            o_reg_a <= i_reg_a;
            o_reg_b <= i_reg_b;
        end
    end

    a_stall_hold: assert property (@(posedge clk) disable iff (i_rst)
        i_stall |=> $stable({o_valid, o_op, o_rs, o_rt, o_rd, o_imm, o_reg_a, o_reg_b}))
        else $error("ID/EX contents changed during a stall");

endmodule

`default_nettype wire

// ==== hdl/decode_subsystem.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_subsystem #(
    parameter int NUM_REGISTERS = 32
) (
    input  wire logic                            clk,
    input  wire logic                            i_rst,
    input  wire logic                            i_stall,
    input  wire logic [mips_pkg::XLEN-1:0]       i_instruction,
    input  wire logic                            i_w_en,
    input  wire logic [mips_pkg::REG_ADDR_W-1:0] i_w_addr,
    input  wire logic [mips_pkg::XLEN-1:0]       i_w_data,
    input  wire logic [mips_pkg::REG_ADDR_W-1:0] i_rd_id_ex,
    input  wire logic                            i_wr_id_ex,
    input  wire logic [mips_pkg::XLEN-1:0]       i_data_id_ex,
    input  wire logic [mips_pkg::REG_ADDR_W-1:0] i_rd_ex_mem,
    input  wire logic                            i_wr_ex_mem,
    input  wire logic [mips_pkg::XLEN-1:0]       i_data_ex_mem,
    input  wire logic [mips_pkg::REG_ADDR_W-1:0] i_rd_mem_wb,
    input  wire logic                            i_wr_mem_wb,
    input  wire logic [mips_pkg::XLEN-1:0]       i_data_mem_wb,
    output logic                                 o_valid,
    output logic [mips_pkg::OP_W-1:0]            o_op,
    output logic [mips_pkg::REG_ADDR_W-1:0]      o_rs,
    output logic [mips_pkg::REG_ADDR_W-1:0]      o_rt,
    output logic [mips_pkg::REG_ADDR_W-1:0]      o_rd,
    output logic [mips_pkg::XLEN-1:0]            o_imm,
    output logic [mips_pkg::XLEN-1:0]            o_reg_a,
    output logic [mips_pkg::XLEN-1:0]            o_reg_b
);
    import mips_pkg::*;

    logic [OP_W-1:0]       dec_op;
    logic [REG_ADDR_W-1:0] dec_rs;
    logic [REG_ADDR_W-1:0] dec_rt;
    logic [REG_ADDR_W-1:0] dec_rd;
    logic [XLEN-1:0]       dec_imm;
    logic [XLEN-1:0]       dec_reg_a;
    logic [XLEN-1:0]       dec_reg_b;

    fwd_bus_if fwd ();

    assign fwd.rd_id_ex    = i_rd_id_ex;
    assign fwd.wr_id_ex    = i_wr_id_ex;
    assign fwd.data_id_ex  = i_data_id_ex;
    assign fwd.rd_ex_mem   = i_rd_ex_mem;
    assign fwd.wr_ex_mem   = i_wr_ex_mem;
    assign fwd.data_ex_mem = i_data_ex_mem;
    assign fwd.rd_mem_wb   = i_rd_mem_wb;
    assign fwd.wr_mem_wb   = i_wr_mem_wb;
    assign fwd.data_mem_wb = i_data_mem_wb;

    instruction_decode #(
        .NUM_REGISTERS(NUM_REGISTERS)
    ) instruction_decode_i (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_instruction (i_instruction), // viewed as instr_u inside
        .i_w_en        (i_w_en),
        .i_w_addr      (i_w_addr),
        .i_w_data      (i_w_data),
        .fwd           (fwd.dst),
        .o_op          (dec_op),
        .o_rs          (dec_rs),
        .o_rt          (dec_rt),
        .o_rd          (dec_rd),
        .o_imm         (dec_imm),
        .o_reg_a       (dec_reg_a),
        .o_reg_b       (dec_reg_b)
    );

    id_ex_register id_ex_register_i (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_stall (i_stall),
        .i_op    (dec_op),
        .i_rs    (dec_rs),
        .i_rt    (dec_rt),
        .i_rd    (dec_rd),
        .i_imm   (dec_imm),
        .i_reg_a (dec_reg_a),
        .i_reg_b (dec_reg_b),
        .o_valid (o_valid),
        .o_op    (o_op),
        .o_rs    (o_rs),
        .o_rt    (o_rt),
        .o_rd    (o_rd),
        .o_imm   (o_imm),
        .o_reg_a (o_reg_a),
        .o_reg_b (o_reg_b)
    );

endmodule

`default_nettype wire

// ==== test/tb_decode_subsystem.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_decode_subsystem;
    import mips_pkg::*;

    localparam int MAX_CYCLES = 600;

    logic        clk;
    logic        rst;
    logic        stall;
    logic [31:0] instruction;
    logic        w_en;
    logic [4:0]  w_addr;
    logic [31:0] w_data;
    logic [4:0]  fwd_rd [3]; // index 0 ID/EX, 1 EX/MEM, 2 MEM/WB
    logic        fwd_wr [3];
    logic [31:0] fwd_data [3];
    logic        valid;
    logic [5:0]  op;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [31:0] imm;
    logic [31:0] reg_a;
    logic [31:0] reg_b;
    logic [31:0] model_regs [32];
    integer      seed;
    int          cycle_count;

    decode_subsystem #(.NUM_REGISTERS(32)) decode_subsystem_i (
        .clk(clk), .i_rst(rst), .i_stall(stall), .i_instruction(instruction),
        .i_w_en(w_en), .i_w_addr(w_addr), .i_w_data(w_data),
        .i_rd_id_ex(fwd_rd[0]), .i_wr_id_ex(fwd_wr[0]), .i_data_id_ex(fwd_data[0]),
        .i_rd_ex_mem(fwd_rd[1]), .i_wr_ex_mem(fwd_wr[1]), .i_data_ex_mem(fwd_data[1]),
        .i_rd_mem_wb(fwd_rd[2]), .i_wr_mem_wb(fwd_wr[2]), .i_data_mem_wb(fwd_data[2]),
        .o_valid(valid), .o_op(op), .o_rs(rs), .o_rt(rt), .o_rd(rd),
        .o_imm(imm), .o_reg_a(reg_a), .o_reg_b(reg_b)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
        fail_run("timeout");
    end

    task automatic fail_run(input string reason);
        $display("=== FAIL ===");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            fail_run("output mismatch");
        end
    endtask

    task automatic step();
        @(posedge clk);
        #2; // inputs change just after the edge
    endtask

    function automatic instr_u make_r(input logic [5:0] f_op, input logic [4:0] f_rs,
                                      input logic [4:0] f_rt, input logic [4:0] f_rd);
        instr_u word;
        word.rtype.op    = f_op;
        word.rtype.rs    = f_rs;
        word.rtype.rt    = f_rt;
        word.rtype.rd    = f_rd;
        word.rtype.shamt = 5'd0;
        word.rtype.funct = 6'h20;
        return word;
    endfunction

    function automatic instr_u make_i(input logic [5:0] f_op, input logic [4:0] f_rs,
                                      input logic [4:0] f_rt, input logic [15:0] f_imm);
        instr_u word;
        word.itype.op    = f_op;
        word.itype.rs    = f_rs;
        word.itype.rt    = f_rt;
        word.itype.imm16 = f_imm;
        return word;
    endfunction

    function automatic logic [31:0] model_read(input logic [4:0] addr);
        return (addr == 5'd0) ? 32'd0 : model_regs[addr];
    endfunction

    task automatic drive_write(input logic [4:0] addr, input logic [31:0] data);
        w_en   = 1'b1;
        w_addr = addr;
        w_data = data;
        if (addr != 5'd0) model_regs[addr] = data; // r0 ignores writes
    endtask

    task automatic write_register(input logic [4:0] addr, input logic [31:0] data);
        drive_write(addr, data);
        step();
        w_en = 1'b0;
    endtask

    task automatic set_stage(input int stage, input logic [4:0] dest, input logic wr,
                             input logic [31:0] data);
        fwd_rd[stage]   = dest;
        fwd_wr[stage]   = wr;
        fwd_data[stage] = data;
    endtask

    task automatic clear_forwarding();
        for (int s = 0; s < 3; s++) set_stage(s, 5'd0, 1'b0, 32'd0);
    endtask

    // fields come straight from the bit positions of the word
    task automatic check_outputs(input logic [31:0] word, input logic [31:0] exp_a,
                                 input logic [31:0] exp_b);
        check_value("o_valid", 32'(valid), 32'd1);
        check_value("o_op", 32'(op), 32'(word[31:26]));
        check_value("o_rs", 32'(rs), 32'(word[25:21]));
        check_value("o_rt", 32'(rt), 32'(word[20:16]));
        check_value("o_rd", 32'(rd), 32'(word[15:11]));
        check_value("o_imm", imm, 32'($signed(word[15:0])));
        check_value("o_reg_a", reg_a, exp_a);
        check_value("o_reg_b", reg_b, exp_b);
    endtask

    task automatic issue_and_check(input instr_u word, input logic [31:0] exp_a,
                                   input logic [31:0] exp_b);
        instruction = word;
        step();
        check_outputs(word, exp_a, exp_b);
    endtask

    task automatic reset_state();
        check_value("o_valid", 32'(valid), 32'd0);
        check_value("o_op", 32'(op), 32'd0);
        check_value("o_rs", 32'(rs), 32'd0);
        check_value("o_rt", 32'(rt), 32'd0);
        check_value("o_rd", 32'(rd), 32'd0);
        check_value("o_imm", imm, 32'd0);
        check_value("o_reg_a", reg_a, 32'd0);
        check_value("o_reg_b", reg_b, 32'd0);
        issue_and_check(make_r(6'h00, 5'd1, 5'd2, 5'd3), 32'd0, 32'd0);
    endtask

    task automatic decode_fields();
        issue_and_check(make_r(6'h00, 5'd17, 5'd18, 5'd19), model_read(17), model_read(18));
        issue_and_check(make_i(6'h08, 5'd21, 5'd22, 16'h1234), model_read(21), model_read(22));
        check_value("o_imm", imm, 32'h0000_1234);
        issue_and_check(make_i(6'h23, 5'd29, 5'd30, 16'hf00d), model_read(29), model_read(30));
        check_value("o_imm", imm, 32'hffff_f00d);
    endtask

    task automatic register_read_write();
        logic [4:0]  addrs [6];
        logic [31:0] value;
        instr_u      word;
        for (int k = 0; k < 6; k++) begin
            value    = $random(seed);
            addrs[k] = (value[4:0] == 5'd0) ? 5'd31 : value[4:0];
            write_register(addrs[k], $random(seed));
        end
        for (int k = 0; k < 6; k++) begin
            word = make_r(6'h00, addrs[k], addrs[(k + 1) % 6], 5'd2);
            issue_and_check(word, model_read(addrs[k]), model_read(addrs[(k + 1) % 6]));
        end
        write_register(5'd0, 32'hdead_beef);
        issue_and_check(make_r(6'h00, 5'd0, addrs[0], 5'd3), 32'd0, model_read(addrs[0]));
        value = $random(seed);
        word  = make_r(6'h00, addrs[1], 5'd0, 5'd4);
        drive_write(addrs[1], value); // same-cycle write and read
        issue_and_check(word, value, 32'd0);
        w_en = 1'b0;
        issue_and_check(word, value, 32'd0);
    endtask

    task automatic forwarding_priority();
        logic [31:0] d_id;
        logic [31:0] d_ex;
        logic [31:0] d_wb;
        instr_u      word;
        d_id = $random(seed);
        d_ex = $random(seed);
        d_wb = $random(seed);
        write_register(5'd7, $random(seed));
        write_register(5'd8, $random(seed));
        word = make_r(6'h00, 5'd7, 5'd8, 5'd9);
        set_stage(0, 5'd7, 1'b1, d_id);
        issue_and_check(word, d_id, model_read(8));
        clear_forwarding();
        set_stage(1, 5'd8, 1'b1, d_ex);
        issue_and_check(word, model_read(7), d_ex);
        clear_forwarding();
        set_stage(2, 5'd7, 1'b1, d_wb);
        issue_and_check(word, d_wb, model_read(8));
        set_stage(0, 5'd7, 1'b1, d_id);
        set_stage(1, 5'd7, 1'b1, d_ex);
        issue_and_check(word, d_id, model_read(8));
        clear_forwarding();
        set_stage(1, 5'd8, 1'b1, d_ex);
        set_stage(2, 5'd8, 1'b1, d_wb);
        issue_and_check(word, model_read(7), d_ex);
        clear_forwarding();
        set_stage(0, 5'd7, 1'b0, d_id);
        issue_and_check(word, model_read(7), model_read(8));
        for (int s = 0; s < 3; s++) set_stage(s, 5'd0, 1'b1, d_wb);
        issue_and_check(make_r(6'h00, 5'd0, 5'd0, 5'd9), 32'd0, 32'd0);
        clear_forwarding();
    endtask

    task automatic stall_hold();
        instr_u      word_a;
        logic [31:0] exp_a;
        logic [31:0] exp_b;
        word_a = make_i(6'h23, 5'd7, 5'd10, 16'h8001);
        exp_a  = model_read(7);
        exp_b  = model_read(10);
        issue_and_check(word_a, exp_a, exp_b);
        stall = 1'b1;
        for (int k = 0; k < 3; k++) begin
            instruction = $random(seed);
            set_stage(0, 5'd7, 1'b1, $random(seed));
            step();
            check_outputs(word_a, exp_a, exp_b);
        end
        stall = 1'b0;
        clear_forwarding();
        issue_and_check(make_r(6'h2b, 5'd8, 5'd7, 5'd12), model_read(8), model_read(7));
    endtask

    initial begin
        seed        = 32'had87_8686;
        rst         = 1'b1;
        stall       = 1'b0;
        instruction = 32'd0;
        w_en        = 1'b0;
        w_addr      = 5'd0;
        w_data      = 32'd0;
        clear_forwarding();
        for (int k = 0; k < 32; k++) model_regs[k] = 32'd0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        reset_state();
        decode_fields();
        register_read_write();
        forwarding_priority();
        stall_hold();
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
hdl/mips_pkg.sv
hdl/fwd_bus_if.sv
hdl/register_bank.sv
hdl/forwarding_unit.sv
hdl/instruction_decode.sv
hdl/id_ex_register.sv
hdl/decode_subsystem.sv
test/tb_decode_subsystem.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_decode_subsystem
RTL_TOP   ?= decode_subsystem
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing
RTL_SRCS  ?= $(shell grep '^hdl/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
